//--- stereo_mixer.f
+incdir+include
hdl/audio_pkg.sv
hdl/mix_ctrl_pkg.sv
hdl/channel_front.sv
hdl/stereo_crossfeed.sv
hdl/stereo_mixer.sv
testbench/tb_stereo_mixer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the stereo mixer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f stereo_mixer.f --top-module tb_stereo_mixer -o tb_stereo_mixer

output="$(./obj_dir/tb_stereo_mixer)"
echo "$output"

if echo "$output" | grep -qx "PASS: all tests"; then
	exit 0
else
	exit 1
fi

//--- include/mixer_model.svh
// Reference model of the mixer arithmetic for the testbench
// Include inside a module after audio_pkg and mix_ctrl_pkg are compiled
// Works on plain integers and models the 17-bit wrap by hand
`ifndef MIXER_MODEL_SVH
`define MIXER_MODEL_SVH

// Fold an integer into the signed range of the wide datapath
function automatic int wrap_wide(input int v);
	int span;
	int w;
	span = 1 << audio_pkg::WIDE_W;
	w = v & (span - 1);
	if (w >= span / 2) begin
		w = w - span;
	end
	return w;
endfunction

// Core conversion plus host sample as seen at the crossfeed input
function automatic int front_sum(input audio_pkg::sample_t core,
		input audio_pkg::sample_t host, input logic is_signed);
	int c;
	c = is_signed ? int'(core) : int'($unsigned(core)) / 2;
	return wrap_wide(c + int'(host));
endfunction

function automatic audio_pkg::sample_t pre_from_sum(input int sum);
	return audio_pkg::sample_t'(sum >>> 1);
endfunction

// Crossfeed, attenuation and clamp of one channel
function automatic audio_pkg::sample_t expected_channel(input int own,
		input audio_pkg::sample_t other_pre, input mix_ctrl_pkg::mix_mode_t mode,
		input mix_ctrl_pkg::att_t att);
	int p;
	int m;
	int a;
	p = int'(other_pre);
	case (mode)
		mix_ctrl_pkg::MIX_LIGHT:  m = wrap_wide(own - (own >>> 3) + (p >>> 2));
		mix_ctrl_pkg::MIX_MEDIUM: m = wrap_wide(own - (own >>> 2) + (p >>> 1));
		mix_ctrl_pkg::MIX_MONO:   m = wrap_wide((own >>> 1) + p);
		default:                  m = own;
	endcase
	a = att[mix_ctrl_pkg::ATT_SHIFT_W] ? 0 : m >>> att[mix_ctrl_pkg::ATT_SHIFT_W-1:0];
	if (a > 32767) begin
		a = 32767;
	end else if (a < -32768) begin
		a = -32768;
	end
	return audio_pkg::sample_t'(a);
endfunction

`endif

//--- testbench/tb_stereo_mixer.sv
// Random stimulus testbench for the stereo mixer
// Inputs change on the falling edge and handshakes are sampled 1 ns later
// Expected results come from the model in mixer_model.svh
`timescale 1ns/1ps

module tb_stereo_mixer;
	import audio_pkg::*;
	import mix_ctrl_pkg::*;

	`include "mixer_model.svh"

	localparam int CLK_PERIOD    = 100;
	localparam int RESET_CYCLES  = 10;
	localparam int N_SAMPLES     = 2000;
	localparam int PLAIN_SAMPLES = 400;
	localparam int DRAIN_CYCLES  = 100;
	localparam logic [31:0] SEED = 32'hcec8bb83;

	logic clk, resetd, i_valid, i_is_signed, i_ready, o_ready, o_valid;
	sample_t i_core_l, i_core_r, i_host_l, i_host_r, o_left, o_right;
	mix_mode_t i_mode;
	att_t i_att;

	logic [31:0] rng;
	sample_t exp_l_q[$];
	sample_t exp_r_q[$];
	sample_t held_l, held_r;
	logic in_pending, out_stall;
	int value_errors, protocol_errors, sent, received;

	stereo_mixer DUT (
		.clk(clk), .resetd(resetd), .i_valid(i_valid),
		.i_core_l(i_core_l), .i_core_r(i_core_r), .i_host_l(i_host_l), .i_host_r(i_host_r),
		.i_is_signed(i_is_signed), .i_mode(i_mode), .i_att(i_att), .o_ready(o_ready),
		.i_ready(i_ready), .o_valid(o_valid), .o_left(o_left), .o_right(o_right)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic next_random(output logic [31:0] r);
		rng = xorshift32(rng);
		r = rng;
	endtask

	// Zero, minus one, max and min for k of 0 to 3
	function automatic sample_t full_scale(input logic [1:0] k);
		return k[1] ? sample_t'({k[0], {15{~k[0]}}}) : sample_t'({16{k[0]}});
	endfunction

	task automatic compare_sample(input string name, input sample_t got, input sample_t expected);
		if (got !== expected) begin
			$display("** Error: %s got %h expected %h", name, got, expected);
			value_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("** Error: %s got %h expected %h", name, got, expected);
			value_errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus and scoreboard
	//////////////////////////////////////////////////////////////////////

	task automatic drive_sample();
		logic [31:0] r;
		next_random(r);
		{i_core_r, i_core_l} = r;
		next_random(r);
		{i_host_r, i_host_l} = r;
		next_random(r);
		i_is_signed = r[0];
		// Full-scale corners for the clamp and crossfeed paths
		if (r[3:2] == 2'b00) begin
			i_core_l = full_scale(r[5:4]);
			i_core_r = full_scale(r[7:6]);
			i_host_l = full_scale(r[9:8]);
			i_host_r = full_scale(r[11:10]);
		end
		if (sent < PLAIN_SAMPLES) begin
			i_mode = MIX_NONE;
			i_att = '0;
		end else begin
			i_mode = mix_mode_t'(r[13:12]);
			i_att = {r[19:16] == 4'd0, r[14] ? r[23:20] : {2'b00, r[21:20]}};
		end
	endtask

	task automatic push_expected();
		int sum_l;
		int sum_r;
		sum_l = front_sum(i_core_l, i_host_l, i_is_signed);
		sum_r = front_sum(i_core_r, i_host_r, i_is_signed);
		exp_l_q.push_back(expected_channel(sum_l, pre_from_sum(sum_r), i_mode, i_att));
		exp_r_q.push_back(expected_channel(sum_r, pre_from_sum(sum_l), i_mode, i_att));
	endtask

	task automatic check_output();
		if (exp_l_q.size() == 0) begin
			$display("Output taken with no matching input, left %h right %h", o_left, o_right);
			protocol_errors++;
		end else begin
			compare_sample("o_left", o_left, exp_l_q.pop_front());
			compare_sample("o_right", o_right, exp_r_q.pop_front());
			received++;
		end
	endtask

	task automatic step_cycle(input logic feed);
		logic [31:0] r;
		@(negedge clk);
		next_random(r);
		if (!in_pending) begin
			i_valid = feed && (r[2:0] != 3'd0);
			if (i_valid) begin
				drive_sample();
			end
		end
		i_ready = r[15:8] < 8'd179;
		#1;
		if (out_stall) begin
			check_flag("o_valid held", o_valid, 1'b1);
			compare_sample("o_left held", o_left, held_l);
			compare_sample("o_right held", o_right, held_r);
		end
		if (i_valid && o_ready) begin
			push_expected();
			sent++;
		end
		if (o_valid && i_ready) begin
			check_output();
		end
		in_pending = i_valid && !o_ready;
		out_stall = o_valid && !i_ready;
		held_l = o_left;
		held_r = o_right;
	endtask

	initial begin
		rng = SEED;
		{resetd, i_valid, i_is_signed, i_ready} = 4'b1000;
		{i_core_l, i_core_r, i_host_l, i_host_r} = '0;
		i_mode = MIX_NONE;
		i_att = '0;
		{in_pending, out_stall, held_l, held_r} = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		resetd = 1'b0;
		#1;
		check_flag("o_valid", o_valid, 1'b0);
		check_flag("o_ready", o_ready, 1'b1);
		while (sent < N_SAMPLES) begin
			step_cycle(1'b1);
		end
		repeat (DRAIN_CYCLES) step_cycle(1'b0);
		if (exp_l_q.size() != 0) begin
			$display("%0d accepted samples never came out", exp_l_q.size());
			protocol_errors++;
		end
		$display("Errors: %0d value, %0d protocol, %0d of %0d outputs checked",
			value_errors, protocol_errors, received, sent);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(CLK_PERIOD * (N_SAMPLES * 4 + RESET_CYCLES));
		$display("Timeout after %0d clock periods with %0d samples sent",
			N_SAMPLES * 4 + RESET_CYCLES, sent);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- hdl/stereo_mixer.sv
// Stereo mixer of core audio and host audio in a five stage pipeline
// Valid/ready on both sides with one advance enable for all stages
// With no back-pressure a result follows its sample by five clocks
// Mode, attenuation and signedness apply to the sample they arrive with
`timescale 1ns/1ps

module stereo_mixer (
	input  logic                    clk,
	input  logic                    resetd,
	input  logic                    i_valid,
	input  audio_pkg::sample_t      i_core_l,
	input  audio_pkg::sample_t      i_core_r,
	input  audio_pkg::sample_t      i_host_l,
	input  audio_pkg::sample_t      i_host_r,
	input  logic                    i_is_signed,
	input  mix_ctrl_pkg::mix_mode_t i_mode,
	input  mix_ctrl_pkg::att_t      i_att,
	output logic                    o_ready,
	input  logic                    i_ready,
	output logic                    o_valid,
	output audio_pkg::sample_t      o_left,
	output audio_pkg::sample_t      o_right
);
	import audio_pkg::*;
	import mix_ctrl_pkg::*;

	logic      adv_en;
	logic      front_valid;
	wide_t     sum_l;
	wide_t     sum_r;
	sample_t   pre_l;
	sample_t   pre_r;

	// Sideband delayed to line up with the front end outputs
	mix_mode_t mode_d1;
	mix_mode_t mode_d2;
	att_t      att_d1;
	att_t      att_d2;

	// Move everything when the output slot is free or being taken
	assign adv_en  = ~o_valid | i_ready;
	assign o_ready = adv_en;

	always_ff @(posedge clk) begin
		if (adv_en) begin
			mode_d1 <= i_mode;
			att_d1  <= i_att;
			mode_d2 <= mode_d1;
			att_d2  <= att_d1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Channel front ends
	//////////////////////////////////////////////////////////////////////

	channel_front front_l (
		.clk         (clk),
		.resetd      (resetd),
		.i_en        (adv_en),
		.i_valid     (i_valid),
		.i_core      (i_core_l),
		.i_host      (i_host_l),
		.i_is_signed (i_is_signed),
		.o_valid     (front_valid),
		.o_sum       (sum_l),
		.o_pre       (pre_l)
	);

	// Runs in lockstep with the left side so its valid matches
	channel_front front_r (
		.clk         (clk),
		.resetd      (resetd),
		.i_en        (adv_en),
		.i_valid     (i_valid),
		.i_core      (i_core_r),
		.i_host      (i_host_r),
		.i_is_signed (i_is_signed),
		.o_valid     (),
		.o_sum       (sum_r),
		.o_pre       (pre_r)
	);

	stereo_crossfeed crossfeed (
		.clk     (clk),
		.resetd  (resetd),
		.i_en    (adv_en),
		.i_valid (front_valid),
		.i_sum_l (sum_l),
		.i_sum_r (sum_r),
		.i_pre_l (pre_l),
		.i_pre_r (pre_r),
		.i_mode  (mode_d2),
		.i_att   (att_d2),
		.o_valid (o_valid),
		.o_left  (o_left),
		.o_right (o_right)
	);

endmodule

//--- hdl/stereo_crossfeed.sv
// Crossfeed, attenuation and clamp for both channels in three stages
// Arithmetic is 17 bits with flooring shifts and wraps until the clamp
// Each channel mixes in the pre value of the opposite channel
// All stages hold while i_en is low
`timescale 1ns/1ps

module stereo_crossfeed (
	input  logic                    clk,
	input  logic                    resetd,
	input  logic                    i_en,
	input  logic                    i_valid,
	input  audio_pkg::wide_t        i_sum_l,
	input  audio_pkg::wide_t        i_sum_r,
	input  audio_pkg::sample_t      i_pre_l,
	input  audio_pkg::sample_t      i_pre_r,
	input  mix_ctrl_pkg::mix_mode_t i_mode,
	input  mix_ctrl_pkg::att_t      i_att,
	output logic                    o_valid,
	output audio_pkg::sample_t      o_left,
	output audio_pkg::sample_t      o_right
);
	import audio_pkg::*;
	import mix_ctrl_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Per-channel arithmetic
	//////////////////////////////////////////////////////////////////////

	function automatic wide_t mix_one(input wide_t own, input sample_t other_pre,
			input mix_mode_t mode);
		wide_t other;
		wide_t res;
		other = {other_pre[SAMPLE_W-1], other_pre};
		case (mode)
			MIX_LIGHT:  res = own - (own >>> 3) + (other >>> 2);
			MIX_MEDIUM: res = own - (own >>> 2) + (other >>> 1);
			MIX_MONO:   res = (own >>> 1) + other;
			default:    res = own;
		endcase
		return res;
	endfunction

	function automatic wide_t atten(input wide_t v, input att_t att);
		wide_t res;
		if (att[ATT_SHIFT_W]) begin
			res = '0;
		end else begin
			res = v >>> att[ATT_SHIFT_W-1:0];
		end
		return res;
	endfunction

	// Top two bits differ when the value is outside the 16-bit range
	function automatic sample_t clamp(input wide_t v);
		sample_t res;
		if (v[WIDE_W-1] != v[WIDE_W-2]) begin
			res = {v[WIDE_W-1], {(SAMPLE_W-1){~v[WIDE_W-1]}}};
		end else begin
			res = v[SAMPLE_W-1:0];
		end
		return res;
	endfunction

	// Mix stage
	logic  mix_valid;
	wide_t mix_l;
	wide_t mix_r;
	att_t  mix_att;

	// Attenuate stage
	logic  att_valid;
	wide_t att_l;
	wide_t att_r;

	//////////////////////////////////////////////////////////////////////
	// Valid bits
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			mix_valid <= 1'b0;
			att_valid <= 1'b0;
			o_valid   <= 1'b0;
		end else if (i_en) begin
			mix_valid <= i_valid;
			att_valid <= mix_valid;
			o_valid   <= att_valid;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Data stages
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (i_en) begin
			// Left takes the right pre value and the other way round
			mix_l   <= mix_one(i_sum_l, i_pre_r, i_mode);
			mix_r   <= mix_one(i_sum_r, i_pre_l, i_mode);
			mix_att <= i_att;

			att_l   <= atten(mix_l, mix_att);
			att_r   <= atten(mix_r, mix_att);

			o_left  <= clamp(att_l);
			o_right <= clamp(att_r);
		end
	end

endmodule

//--- hdl/channel_front.sv
// Front end of one mixer channel with two register stages
// Unsigned core audio is halved so it sits in the same range as signed audio
// The host sum wraps in 17 bits and is not saturated here
// Both stages hold while i_en is low
`timescale 1ns/1ps

module channel_front (
	input  logic               clk,
	input  logic               resetd,
	input  logic               i_en,
	input  logic               i_valid,
	input  audio_pkg::sample_t i_core,
	input  audio_pkg::sample_t i_host,
	input  logic               i_is_signed,
	output logic               o_valid,
	output audio_pkg::wide_t   o_sum,
	output audio_pkg::sample_t o_pre
);
	import audio_pkg::*;

	// Stage one
	logic    s1_valid;
	wide_t   s1_core;
	sample_t s1_host;

	wide_t   core_conv;
	wide_t   host_ext;
	wide_t   sum_next;

	//////////////////////////////////////////////////////////////////////
	// Conversion and sum
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (i_is_signed) begin
			core_conv = {i_core[SAMPLE_W-1], i_core};
		end else begin
			// Drop the LSB of offset binary audio and keep it positive
			core_conv = {2'b00, i_core[SAMPLE_W-1:1]};
		end
	end

	assign host_ext = {s1_host[SAMPLE_W-1], s1_host};
	assign sum_next = s1_core + host_ext;

	//////////////////////////////////////////////////////////////////////
	// Pipeline registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			s1_valid <= 1'b0;
			o_valid  <= 1'b0;
		end else if (i_en) begin
			s1_valid <= i_valid;
			o_valid  <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (i_en) begin
			s1_core <= core_conv;
			s1_host <= i_host;
			o_sum   <= sum_next;
			// Pre value for the other channel is the sum halved
			o_pre   <= sum_next[WIDE_W-1:1];
		end
	end

endmodule

//--- hdl/mix_ctrl_pkg.sv
// Control sideband of the stereo mixer
// Mode and attenuation travel with each sample
// An attenuation with the top bit set mutes the sample

package mix_ctrl_pkg;

	// Crossfeed strength toward the opposite channel
	typedef enum logic [1:0] {
		MIX_NONE   = 2'd0,
		MIX_LIGHT  = 2'd1,
		MIX_MEDIUM = 2'd2,
		MIX_MONO   = 2'd3
	} mix_mode_t;

	//////////////////////////////////////////////////////////////////////
	// Attenuation
	//////////////////////////////////////////////////////////////////////

	// Shift count field width for 0 to 15 right shifts
	localparam int ATT_SHIFT_W = 4;

	// Bit ATT_SHIFT_W mutes and the bits below give the shift count
	typedef logic [ATT_SHIFT_W:0] att_t;

endpackage

//--- hdl/audio_pkg.sv
// Sample formats shared by the stereo mixer datapath
// All samples are two's complement
// The wide format has one guard bit for the core plus host sum

package audio_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	// Width of every sample on the mixer ports
	localparam int SAMPLE_W = 16;

	// Internal width used from the host sum up to the clamp
	localparam int WIDE_W = SAMPLE_W + 1;

	//////////////////////////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////////////////////////

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// Wraps on overflow and is saturated only at the output
	typedef logic signed [WIDE_W-1:0] wide_t;

endpackage
